// File: vec_unit.f
+incdir+verilog
verilog/vec_pkg.sv
verilog/vec_queue.sv
verilog/vec_dispatcher.sv
verilog/vec_sequencer.sv
verilog/vec_lane.sv
verilog/vec_unit.sv
sim/tb_vec_unit.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the vec_unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
    -f vec_unit.f --top-module tb_vec_unit -o Vtb_vec_unit; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/Vtb_vec_unit > "$LOG" 2>&1; then
  cat "$LOG"
  echo "Simulation exited with an error"
  exit 1
fi

cat "$LOG"

if grep -qx "TEST OK" "$LOG"; then
  exit 0
fi

echo "Pass message not found in $LOG"
exit 1

// File: sim/tb_vec_unit.sv
`default_nettype none

`include "vec_config.svh"

module tb_vec_unit;

  import vec_pkg::*;

  localparam int          NrLanes    = `VEC_NR_LANES;
  localparam int          NrVregs    = `VEC_NR_VREGS;
  localparam int          NrArith    = 24;
  localparam int          NrBurst    = `VEC_INSN_DEPTH + 4;
  localparam int unsigned Seed       = 32'h49c09e05;
  localparam logic [2:0]  OpReserved = 3'd7;

  // Splat and its extracts, register fill, arithmetic pairs, reserved pair, burst pairs
  localparam int NrTrans   = 1 + NrLanes + NrVregs + 2 * NrArith + 2 + 2 * NrBurst;
  localparam int MaxCycles = 200 * NrTrans;

  logic      clk = 1'b0;
  logic      rst_n = 1'b0;
  logic      acc_req;
  acc_insn_t acc_insn;
  logic      acc_ack;
  acc_resp_t acc_resp;
  logic      idle;

  // Reference register file, one element per register and lane
  elem_t     ref_q [NrVregs][NrLanes];
  elem_t     exp_result = '0;
  logic      exp_error = 1'b0;
  logic      exp_is_ext = 1'b0;
  vreg_idx_t burst_vd [$];

  vec_unit u_dut (
    .clk_i      (clk     ),
    .rst_n_i    (rst_n   ),
    .acc_req_i  (acc_req ),
    .acc_insn_i (acc_insn),
    .acc_ack_o  (acc_ack ),
    .acc_resp_o (acc_resp),
    .idle_o     (idle    )
  );

  initial begin
    forever #5 clk = ~clk;
  end

  task automatic fail_now(input string what);
    $display("%s", what);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  ////////////////////
  // Checks
  ////////////////////

  assert property (@(posedge clk) $rose(rst_n) |-> !acc_ack)
    else fail_now($sformatf("error acc_ack_o: got %h expected 0 after reset", $sampled(acc_ack)));

  assert property (@(posedge clk) $rose(rst_n) |-> idle)
    else fail_now($sformatf("error idle_o: got %h expected 1 after reset", $sampled(idle)));

  assert property (@(posedge clk) disable iff (!rst_n) $rose(acc_ack) |-> $past(acc_req))
    else fail_now("acc_ack_o rose while acc_req_i was low");

  assert property (@(posedge clk) disable iff (!rst_n) acc_ack && acc_req |=> acc_ack)
    else fail_now("acc_ack_o fell while acc_req_i was still high");

  // Core port busy means the unit is busy
  assert property (@(posedge clk) disable iff (!rst_n) acc_ack |-> !idle)
    else fail_now($sformatf("error idle_o: got %h expected 0 while acc_ack_o is high",
                            $sampled(idle)));

  assert property (@(posedge clk) disable iff (!rst_n) $rose(acc_ack) |-> acc_resp.error == exp_error)
    else fail_now($sformatf("error acc_resp_o.error: got %h expected %h",
                            $sampled(acc_resp.error), exp_error));

  // Only an extract carries a result worth checking
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(acc_ack) && exp_is_ext |-> acc_resp.result == exp_result)
    else fail_now($sformatf("error acc_resp_o.result: got %h expected %h",
                            $sampled(acc_resp.result), exp_result));

  initial begin
    repeat (MaxCycles) @(posedge clk);
    fail_now($sformatf("timeout after %0d cycles with the tests still running", MaxCycles));
  end

  ////////////////////
  // Reference model
  ////////////////////

  task automatic update_model(input logic [2:0] op, input vreg_idx_t vd, input vreg_idx_t vs1,
                              input vreg_idx_t vs2, input elem_t scalar);
    elem_t a;
    elem_t b;
    for (int l = 0; l < NrLanes; l++) begin
      a = ref_q[vs1][l];
      b = ref_q[vs2][l];
      case (op)
        3'(VADD):   ref_q[vd][l] = b + a;
        3'(VSUB):   ref_q[vd][l] = b - a;
        3'(VAND):   ref_q[vd][l] = b & a;
        3'(VOR):    ref_q[vd][l] = b | a;
        3'(VXOR):   ref_q[vd][l] = b ^ a;
        3'(VSPLAT): ref_q[vd][l] = scalar;
        // Extract and the reserved opcode leave the registers alone
        default:    ;
      endcase
    end
  endtask

  ////////////////////
  // Core model
  ////////////////////

  task automatic do_insn(input logic [2:0] op, input vreg_idx_t vd, input vreg_idx_t vs1,
                         input vreg_idx_t vs2, input elem_t scalar, input bit drop_now);
    int hold;
    int lane;
    hold       = drop_now ? 0 : int'($urandom % 4);
    lane       = int'(scalar % NrLanes);
    exp_error  = (op == OpReserved);
    exp_is_ext = (op == 3'(VEXT));
    exp_result = ref_q[vs2][lane];
    acc_insn   = '{op: op, vd: vd, vs1: vs1, vs2: vs2, scalar: scalar};
    acc_req    = 1'b1;
    do begin
      @(posedge clk);
      #1;
    end while (!acc_ack);
    update_model(op, vd, vs1, vs2, scalar);
    repeat (hold) begin
      @(posedge clk);
      #1;
    end
    acc_req = 1'b0;
    while (acc_ack) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic do_ext(input vreg_idx_t vs2, input elem_t idx);
    do_insn(3'(VEXT), '0, '0, vs2, idx, 1'b0);
  endtask

  task automatic wait_idle();
    while (!idle) begin
      @(posedge clk);
      #1;
    end
  endtask

  function automatic vreg_idx_t rand_reg();
    return vreg_idx_t'($urandom % NrVregs);
  endfunction

  ////////////////////
  // Stimulus
  ////////////////////

  initial begin
    vreg_idx_t vd;
    elem_t     scalar;
    void'($urandom(Seed));
    acc_req  = 1'b0;
    acc_insn = '0;
    for (int r = 0; r < NrVregs; r++) begin
      for (int l = 0; l < NrLanes; l++) begin
        ref_q[r][l] = '0;
      end
    end
    repeat (2) @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(posedge clk);
    #1;

    // Splat, then read back every lane
    vd     = rand_reg();
    scalar = elem_t'($urandom);
    do_insn(3'(VSPLAT), vd, '0, '0, scalar, 1'b0);
    for (int l = 0; l < NrLanes; l++) begin
      do_ext(vd, elem_t'(l));
    end

    // Fill every register, then random arithmetic with a readback each
    for (int r = 0; r < NrVregs; r++) begin
      do_insn(3'(VSPLAT), vreg_idx_t'(r), '0, '0, elem_t'($urandom), 1'b0);
    end
    for (int i = 0; i < NrArith; i++) begin
      vd = rand_reg();
      do_insn(3'($urandom % 5), vd, rand_reg(), rand_reg(), elem_t'($urandom), 1'b0);
      do_ext(vd, elem_t'($urandom));
    end

    // Reserved opcode must not touch vd
    vd = rand_reg();
    do_insn(OpReserved, vd, rand_reg(), rand_reg(), elem_t'($urandom), 1'b0);
    do_ext(vd, elem_t'($urandom));

    // Back to back burst with req dropped right at ack
    for (int i = 0; i < NrBurst; i++) begin
      vd = rand_reg();
      burst_vd.push_back(vd);
      do_insn(3'($urandom % 5), vd, rand_reg(), rand_reg(), elem_t'($urandom), 1'b1);
    end
    wait_idle();
    foreach (burst_vd[i]) begin
      do_ext(burst_vd[i], elem_t'($urandom));
    end
    wait_idle();

    repeat (2) @(posedge clk);
    $display("TEST OK");
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog/vec_unit.sv
`default_nettype none

`include "vec_config.svh"

module vec_unit (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  input  wire logic               acc_req_i,
  input  wire vec_pkg::acc_insn_t acc_insn_i,
  output logic                    acc_ack_o,
  output vec_pkg::acc_resp_t      acc_resp_o,
  output logic                    idle_o
);

  import vec_pkg::*;

  // Dispatcher to instruction queue
  logic   disp_valid;
  logic   disp_ready;
  vinsn_t disp_insn;
  // Instruction queue to sequencer
  logic   iq_valid;
  logic   iq_ready;
  vinsn_t iq_insn;
  // Sequencer to result queue
  logic   rq_push_valid;
  logic   rq_push_ready;
  elem_t  rq_push_data;
  // Result queue to dispatcher
  logic   rq_pop_valid;
  logic   rq_pop_ready;
  elem_t  rq_pop_data;
  // Broadcast
  logic                         issue;
  vinsn_t                       lane_insn;
  elem_t  [`VEC_NR_LANES-1:0]   lane_elem;
  logic                         seq_idle;

  ////////////////////
  // Front end
  ////////////////////

  vec_dispatcher u_dispatcher (
    .clk_i        (clk_i       ),
    .rst_n_i      (rst_n_i     ),
    .acc_req_i    (acc_req_i   ),
    .acc_insn_i   (acc_insn_i  ),
    .acc_ack_o    (acc_ack_o   ),
    .acc_resp_o   (acc_resp_o  ),
    .insn_valid_o (disp_valid  ),
    .insn_ready_i (disp_ready  ),
    .insn_o       (disp_insn   ),
    .res_valid_i  (rq_pop_valid),
    .res_ready_o  (rq_pop_ready),
    .res_i        (rq_pop_data ),
    .seq_idle_i   (seq_idle    ),
    .idle_o       (idle_o      )
  );

  vec_queue #(
    .payload_t (vinsn_t        ),
    .DEPTH     (`VEC_INSN_DEPTH)
  ) u_insn_queue (
    .clk_i        (clk_i     ),
    .rst_n_i      (rst_n_i   ),
    .push_valid_i (disp_valid),
    .push_ready_o (disp_ready),
    .push_data_i  (disp_insn ),
    .pop_valid_o  (iq_valid  ),
    .pop_ready_i  (iq_ready  ),
    .pop_data_o   (iq_insn   ),
    .empty_o      (          )
  );

  vec_queue #(
    .payload_t (elem_t        ),
    .DEPTH     (`VEC_RES_DEPTH)
  ) u_res_queue (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .push_valid_i (rq_push_valid),
    .push_ready_o (rq_push_ready),
    .push_data_i  (rq_push_data ),
    .pop_valid_o  (rq_pop_valid ),
    .pop_ready_i  (rq_pop_ready ),
    .pop_data_o   (rq_pop_data  ),
    .empty_o      (             )
  );

  ////////////////////
  // Back end
  ////////////////////

  vec_sequencer u_sequencer (
    .clk_i        (clk_i        ),
    .rst_n_i      (rst_n_i      ),
    .insn_valid_i (iq_valid     ),
    .insn_ready_o (iq_ready     ),
    .insn_i       (iq_insn      ),
    .issue_o      (issue        ),
    .lane_insn_o  (lane_insn    ),
    .lane_elem_i  (lane_elem    ),
    .res_valid_o  (rq_push_valid),
    .res_ready_i  (rq_push_ready),
    .res_o        (rq_push_data ),
    .seq_idle_o   (seq_idle     )
  );

  for (genvar i = 0; i < `VEC_NR_LANES; i++) begin : gen_lanes
    vec_lane u_lane (
      .clk_i      (clk_i       ),
      .rst_n_i    (rst_n_i     ),
      .issue_i    (issue       ),
      .insn_i     (lane_insn   ),
      .ext_elem_o (lane_elem[i])
    );
  end : gen_lanes

endmodule

`default_nettype wire

// File: verilog/vec_lane.sv
`default_nettype none

`include "vec_config.svh"

module vec_lane (
  input  wire logic            clk_i,
  input  wire logic            rst_n_i,
  input  wire logic            issue_i,
  input  wire vec_pkg::vinsn_t insn_i,
  output vec_pkg::elem_t       ext_elem_o
);

  import vec_pkg::*;

  // This lane's element of every vector register
  elem_t vrf_q [`VEC_NR_VREGS];
  elem_t op_a;
  elem_t op_b;
  elem_t alu_res;

  assign op_a = vrf_q[insn_i.vs1];
  assign op_b = vrf_q[insn_i.vs2];

  // Element ALU, wraps modulo 2^ELEN
  always_comb begin
    case (insn_i.op)
      VADD:    alu_res = op_b + op_a;
      // vd = vs2 - vs1
      VSUB:    alu_res = op_b - op_a;
      VAND:    alu_res = op_b & op_a;
      VOR:     alu_res = op_b | op_a;
      VXOR:    alu_res = op_b ^ op_a;
      VSPLAT:  alu_res = insn_i.scalar;
      default: alu_res = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      vrf_q      <= '{default: '0};
      ext_elem_o <= '0;
    end else if (issue_i) begin
      if (insn_i.op == VEXT) begin
        ext_elem_o <= op_b;
      end else begin
        vrf_q[insn_i.vd] <= alu_res;
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/vec_sequencer.sv
`default_nettype none

`include "vec_config.svh"

module vec_sequencer (
  input  wire logic                                clk_i,
  input  wire logic                                rst_n_i,
  // Instruction queue pop
  input  wire logic                                insn_valid_i,
  output logic                                     insn_ready_o,
  input  wire vec_pkg::vinsn_t                     insn_i,
  // Lane broadcast
  output logic                                     issue_o,
  output vec_pkg::vinsn_t                          lane_insn_o,
  input  wire vec_pkg::elem_t [`VEC_NR_LANES-1:0] lane_elem_i,
  // Result queue push
  output logic                                     res_valid_o,
  input  wire logic                                res_ready_i,
  output vec_pkg::elem_t                           res_o,
  // Status
  output logic                                     seq_idle_o
);

  import vec_pkg::*;

  logic      ext_q;
  lane_idx_t sel_q;
  logic      is_ext;
  logic      stall;

  assign is_ext = (insn_i.op == VEXT);

  // One extract at a time, and only with room for its result
  assign stall = is_ext && (ext_q || !res_ready_i);

  ////////////////////
  // Issue
  ////////////////////

  assign issue_o      = insn_valid_i && !stall;
  assign insn_ready_o = issue_o;
  assign lane_insn_o  = insn_i;

  // Lanes hold the extracted elements from the issue edge on
  assign res_valid_o = ext_q;
  assign res_o       = lane_elem_i[sel_q];

  assign seq_idle_o = !insn_valid_i && !ext_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ext_q <= 1'b0;
      sel_q <= '0;
    end else begin
      if (issue_o && is_ext) begin
        ext_q <= 1'b1;
        // Element index taken modulo the lane count
        sel_q <= lane_idx_t'(insn_i.scalar);
      end else if (res_valid_o && res_ready_i) begin
        ext_q <= 1'b0;
      end
    end
  end

  // A pending result holds until the result queue takes it
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_o && !res_ready_i |=> res_valid_o && $stable(res_o));

endmodule

`default_nettype wire

// File: verilog/vec_dispatcher.sv
`default_nettype none

module vec_dispatcher (
  input  wire logic               clk_i,
  input  wire logic               rst_n_i,
  // Core port
  input  wire logic               acc_req_i,
  input  wire vec_pkg::acc_insn_t acc_insn_i,
  output logic                    acc_ack_o,
  output vec_pkg::acc_resp_t      acc_resp_o,
  // Instruction queue push
  output logic                    insn_valid_o,
  input  wire logic               insn_ready_i,
  output vec_pkg::vinsn_t         insn_o,
  // Result queue pop
  input  wire logic               res_valid_i,
  output logic                    res_ready_o,
  input  wire vec_pkg::elem_t     res_i,
  // Status
  input  wire logic               seq_idle_i,
  output logic                    idle_o
);

  import vec_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    PUSH,
    WAIT_RES,
    ACK
  } state_e;

  state_e    state_q;
  acc_insn_t insn_q;
  acc_resp_t resp_q;
  logic      legal;
  logic      is_ext;

  // Anything above VEXT is reserved
  assign legal  = (insn_q.op <= 3'(VEXT));
  assign is_ext = (insn_q.op == 3'(VEXT));

  always_comb begin
    insn_o.op     = vec_op_e'(insn_q.op);
    insn_o.vd     = insn_q.vd;
    insn_o.vs1    = insn_q.vs1;
    insn_o.vs2    = insn_q.vs2;
    insn_o.scalar = insn_q.scalar;
  end

  assign insn_valid_o = (state_q == PUSH) && legal;
  assign res_ready_o  = (state_q == WAIT_RES);
  assign acc_ack_o    = (state_q == ACK);
  assign acc_resp_o   = resp_q;
  assign idle_o       = (state_q == IDLE) && seq_idle_i;

  ////////////////////
  // Core port FSM
  ////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      insn_q  <= '0;
      resp_q  <= '0;
    end else begin
      case (state_q)
        IDLE: begin
          if (acc_req_i) begin
            insn_q  <= acc_insn_i;
            state_q <= PUSH;
          end
        end
        PUSH: begin
          if (!legal) begin
            resp_q  <= '{result: '0, error: 1'b1};
            state_q <= ACK;
          end else if (insn_ready_i) begin
            resp_q  <= '0;
            // Extract has to wait for its element
            state_q <= is_ext ? WAIT_RES : ACK;
          end
        end
        WAIT_RES: begin
          if (res_valid_i) begin
            resp_q  <= '{result: res_i, error: 1'b0};
            state_q <= ACK;
          end
        end
        ACK: begin
          if (!acc_req_i) begin
            state_q <= IDLE;
          end
        end
        default: state_q <= IDLE;
      endcase
    end
  end

  // Core drops req only once it has seen ack
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $fell(acc_req_i) |-> acc_ack_o);

endmodule

`default_nettype wire

// File: verilog/vec_queue.sv
`default_nettype none

module vec_queue #(
  parameter type         payload_t = logic,
  parameter int unsigned DEPTH     = 2
) (
  input  wire logic     clk_i,
  input  wire logic     rst_n_i,
  // Producer side
  input  wire logic     push_valid_i,
  output logic          push_ready_o,
  input  wire payload_t push_data_i,
  // Consumer side
  output logic          pop_valid_o,
  input  wire logic     pop_ready_i,
  output payload_t      pop_data_o,
  output logic          empty_o
);

  localparam int unsigned PtrW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CntW = $clog2(DEPTH + 1);

  payload_t        mem_q [DEPTH];
  logic [PtrW-1:0] rd_ptr_q;
  logic [PtrW-1:0] wr_ptr_q;
  logic [CntW-1:0] cnt_q;
  logic            push;
  logic            pop;

  assign push_ready_o = (cnt_q != CntW'(DEPTH));
  assign pop_valid_o  = (cnt_q != '0);
  assign empty_o      = (cnt_q == '0);
  assign pop_data_o   = mem_q[rd_ptr_q];

  assign push = push_valid_i && push_ready_o;
  assign pop  = pop_valid_o && pop_ready_i;

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PtrW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PtrW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      case ({push, pop})
        2'b10:   cnt_q <= cnt_q + CntW'(1);
        2'b01:   cnt_q <= cnt_q - CntW'(1);
        default: cnt_q <= cnt_q;
      endcase
    end
  end

  // Full or empty queue has its pointers level
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (cnt_q == CntW'(DEPTH)) || (cnt_q == '0) |-> (wr_ptr_q == rd_ptr_q));

  // Level pointers only ever mean full or empty
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (wr_ptr_q == rd_ptr_q) |-> (cnt_q == CntW'(DEPTH)) || (cnt_q == '0));

endmodule

`default_nettype wire

// File: verilog/vec_pkg.sv
`default_nettype none

`include "vec_config.svh"

package vec_pkg;

  ////////////////////
  // Basic types
  ////////////////////

  typedef logic [`VEC_ELEN-1:0] elem_t;
  typedef logic [$clog2(`VEC_NR_VREGS)-1:0] vreg_idx_t;
  typedef logic [$clog2(`VEC_NR_LANES)-1:0] lane_idx_t;

  // Opcode 3'd7 is reserved
  typedef enum logic [2:0] {
    VADD   = 3'd0,
    VSUB   = 3'd1,
    VAND   = 3'd2,
    VOR    = 3'd3,
    VXOR   = 3'd4,
    VSPLAT = 3'd5,
    VEXT   = 3'd6
  } vec_op_e;

  ////////////////////
  // Core port
  ////////////////////

  // Raw opcode field, may carry the reserved value
  typedef struct packed {
    logic [2:0] op;
    vreg_idx_t  vd;
    vreg_idx_t  vs1;
    vreg_idx_t  vs2;
    elem_t      scalar;
  } acc_insn_t;

  typedef struct packed {
    elem_t result;
    logic  error;
  } acc_resp_t;

  // Decoded instruction as stored in the queue and sent to the lanes
  typedef struct packed {
    vec_op_e   op;
    vreg_idx_t vd;
    vreg_idx_t vs1;
    vreg_idx_t vs2;
    elem_t     scalar;
  } vinsn_t;

endpackage

`default_nettype wire

// File: verilog/vec_config.svh
`ifndef VEC_CONFIG_SVH
`define VEC_CONFIG_SVH

// Number of parallel lanes, a power of two
`define VEC_NR_LANES 4

// Element width in bits
`define VEC_ELEN 32

// Architectural vector registers
`define VEC_NR_VREGS 8

// Entries in the instruction queue
`define VEC_INSN_DEPTH 4

// Entries in the extract result queue
`define VEC_RES_DEPTH 2

`endif
